// File: common/evr_pkg.sv
`default_nettype none

package evr_pkg;

    localparam int MMR_ADDR_W = 8;
    localparam int MMR_DATA_W = 32;

    typedef logic [MMR_ADDR_W-1:0] mmr_addr_t;
    typedef logic [MMR_DATA_W-1:0] mmr_data_t;

    // Register map
    localparam mmr_addr_t REG_SR         = 8'h00;
    localparam mmr_addr_t REG_CR         = 8'h04;
    localparam mmr_addr_t REG_CR_S       = 8'h08;
    localparam mmr_addr_t REG_CR_C       = 8'h0C;
    localparam mmr_addr_t REG_TOPO_ID    = 8'h10;
    localparam mmr_addr_t REG_LINK_DELAY = 8'h14;
    localparam mmr_addr_t REG_TGT_DELAY  = 8'h18;
    localparam mmr_addr_t REG_COMP_DELAY = 8'h1C;

    // Link characters
    localparam logic [7:0] BEACON_CODE = 8'h7E;
    localparam logic [7:0] FRAME_K     = 8'h5C;
    localparam logic [7:0] MSG_TOPO    = 8'h01;
    localparam logic [7:0] MSG_DELAY   = 8'h02;

    typedef struct packed {
        logic      awvalid;
        mmr_addr_t awaddr;
        logic      wvalid;
        mmr_data_t wdata;
        logic      bready;
        logic      arvalid;
        mmr_addr_t araddr;
        logic      rready;
    } mmr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        mmr_data_t  rdata;
        logic [1:0] rresp;
    } mmr_rsp_t;

    // Status bit 0 delay valid, bit 1 topology valid, bit 2 frame error
    typedef struct packed {
        logic [31:0] topo_id;
        logic [31:0] delay;
        logic [2:0]  status;
    } link_info_t;

    typedef enum logic [1:0] {
        DC_OFF    = 2'd0,
        DC_ADJUST = 2'd1,
        DC_LOCKED = 2'd2,
        DC_RANGE  = 2'd3
    } dc_status_e;

    typedef struct packed {
        logic [1:0] dc_status;
        logic [2:0] link_status;
        logic       link_up;
    } sr_t;

    typedef struct packed {
        logic dc_ena;
    } cr_t;

endpackage

`default_nettype wire

// File: hw/delay_comp/delay_comp.sv
`timescale 1ns/1ps
`default_nettype none

module delay_comp #(
    parameter int DELAY_DEPTH   = 64,
    parameter int STEP_INTERVAL = 4
) (
    input  logic                rx_clk,
    input  logic                app_rst,
    input  logic                ena_i,
    input  logic                req_upd_i,
    input  evr_pkg::mmr_data_t  delay_req_i,
    input  logic [7:0]          lane_data_i,
    input  logic                lane_k_i,
    output logic [7:0]          ev_o,
    output evr_pkg::mmr_data_t  cur_delay_o,
    output evr_pkg::dc_status_e status_o
);
    import evr_pkg::*;

    localparam int PTR_W = (DELAY_DEPTH > 1) ? $clog2(DELAY_DEPTH) : 1;
    localparam int CNT_W = $clog2(STEP_INTERVAL + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DELAY_DEPTH - 1);

    typedef struct packed {
        logic       k;
        logic [7:0] data;
    } lane_sym_t;

    lane_sym_t        mem [DELAY_DEPTH];
    lane_sym_t        wr_sym;
    lane_sym_t        tap_sym;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] cur_delay;
    logic [PTR_W-1:0] req_delay;
    logic [CNT_W-1:0] step_cnt;
    logic             range_err;

    assign wr_sym.k    = lane_k_i;
    assign wr_sym.data = lane_data_i;

    // Read tap trails the write pointer by cur_delay entries
    always_comb begin
        if (wr_ptr >= cur_delay) begin
            rd_ptr = wr_ptr - cur_delay;
        end else begin
            rd_ptr = PTR_W'(int'(wr_ptr) + DELAY_DEPTH - int'(cur_delay));
        end
    end

    // Zero delay bypasses the ring
    assign tap_sym = (cur_delay == '0) ? wr_sym : mem[rd_ptr];

    always_ff @(posedge rx_clk) begin
        mem[wr_ptr] <= wr_sym;
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            wr_ptr <= '0;
            ev_o   <= '0;
        end else begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            ev_o   <= tap_sym.k ? '0 : tap_sym.data;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            req_delay <= '0;
            range_err <= 1'b0;
            cur_delay <= '0;
            step_cnt  <= '0;
            status_o  <= DC_OFF;
        end else begin
            if (req_upd_i) begin
                if (delay_req_i > mmr_data_t'(DELAY_DEPTH - 1)) begin
                    req_delay <= PTR_LAST;
                    range_err <= 1'b1;
                end else begin
                    req_delay <= PTR_W'(delay_req_i);
                    range_err <= 1'b0;
                end
            end

            // One step per STEP_INTERVAL cycles
            if (ena_i && cur_delay != req_delay) begin
                if (step_cnt == CNT_W'(STEP_INTERVAL - 1)) begin
                    step_cnt  <= '0;
                    cur_delay <= (cur_delay < req_delay) ? cur_delay + 1'b1
                                                         : cur_delay - 1'b1;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end else begin
                step_cnt <= '0;
            end

            if (!ena_i) begin
                status_o <= DC_OFF;
            end else if (range_err) begin
                status_o <= DC_RANGE;
            end else if (cur_delay != req_delay) begin
                status_o <= DC_ADJUST;
            end else begin
                status_o <= DC_LOCKED;
            end
        end
    end

    assign cur_delay_o = mmr_data_t'(cur_delay);

endmodule

`default_nettype wire

// File: hw/event_lane.sv
`timescale 1ns/1ps
`default_nettype none

module event_lane (
    input  logic       rx_clk,
    input  logic       app_rst,
    input  logic       aligned_i,
    input  logic [7:0] lane_data_i,
    input  logic       lane_k_i,
    output logic       link_up_o,
    output logic       beacon_o,
    output logic [7:0] ev_data_o,
    output logic       ev_k_o
);
    import evr_pkg::*;

    logic is_beacon;

    // Beacons are plain data bytes, never K-characters
    assign is_beacon = !lane_k_i && (lane_data_i == BEACON_CODE);

    // Gating on aligned_i here keeps every output at zero while link_up_o is low
    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            link_up_o <= 1'b0;
            beacon_o  <= 1'b0;
            ev_data_o <= '0;
            ev_k_o    <= 1'b0;
        end else begin
            link_up_o <= aligned_i;
            beacon_o  <= aligned_i && is_beacon;
            ev_k_o    <= aligned_i && lane_k_i;
            if (aligned_i && !is_beacon) begin
                ev_data_o <= lane_data_i;
            end else begin
                // Beacon slot left empty in the event stream
                ev_data_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/evr_regs/evr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module evr_regs (
    input  logic                rx_clk,
    input  logic                app_rst,
    input  evr_pkg::mmr_req_t   mmr_req_i,
    output evr_pkg::mmr_rsp_t   mmr_rsp_o,
    input  logic                link_up_i,
    input  evr_pkg::link_info_t info_i,
    input  evr_pkg::dc_status_e dc_status_i,
    input  evr_pkg::mmr_data_t  cur_delay_i,
    output logic                dc_ena_o,
    output evr_pkg::mmr_data_t  delay_req_o,
    output logic                req_upd_o
);
    import evr_pkg::*;

    sr_t       sr;
    cr_t       cr;
    cr_t       wr_cr;
    mmr_addr_t wr_addr;
    mmr_data_t wr_data;
    mmr_data_t tgt_delay;
    mmr_data_t rd_mux;
    mmr_data_t rd_data;
    logic      rd_pend;
    logic      wa_pend;
    logic      wd_pend;
    logic      arready_q;
    logic      awready_q;
    logic      wready_q;
    logic      rd_acc;
    logic      wa_acc;
    logic      wd_acc;
    logic      wr_fire;

    assign sr.dc_status   = dc_status_i;
    assign sr.link_status = info_i.status;
    assign sr.link_up     = link_up_i;

    assign rd_acc  = mmr_req_i.arvalid && !rd_pend;
    assign wa_acc  = mmr_req_i.awvalid && !wa_pend;
    assign wd_acc  = mmr_req_i.wvalid && !wd_pend;
    assign wr_fire = wa_pend && wd_pend && mmr_req_i.bready;
    assign wr_cr   = cr_t'(wr_data[$bits(cr_t)-1:0]);

    // Sampled in the accept cycle, held while rvalid is up
    always_comb begin
        case (mmr_req_i.araddr)
            REG_SR:         rd_mux = mmr_data_t'(sr);
            REG_CR:         rd_mux = mmr_data_t'(cr);
            REG_TOPO_ID:    rd_mux = info_i.topo_id;
            REG_LINK_DELAY: rd_mux = info_i.delay;
            REG_TGT_DELAY:  rd_mux = tgt_delay;
            REG_COMP_DELAY: rd_mux = cur_delay_i;
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge rx_clk) begin
        if (rd_acc) begin
            rd_data <= rd_mux;
        end
        if (wa_acc) begin
            wr_addr <= mmr_req_i.awaddr;
        end
        if (wd_acc) begin
            wr_data <= mmr_req_i.wdata;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            arready_q <= 1'b0;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            rd_pend   <= 1'b0;
            wa_pend   <= 1'b0;
            wd_pend   <= 1'b0;
            cr        <= '0;
            tgt_delay <= '0;
            req_upd_o <= 1'b0;
        end else begin
            arready_q <= rd_acc;
            awready_q <= wa_acc;
            wready_q  <= wd_acc;
            req_upd_o <= 1'b0;

            if (rd_acc) begin
                rd_pend <= 1'b1;
            end else if (rd_pend && mmr_req_i.rready) begin
                rd_pend <= 1'b0;
            end

            if (wa_acc) begin
                wa_pend <= 1'b1;
            end
            if (wd_acc) begin
                wd_pend <= 1'b1;
            end

            if (wr_fire) begin
                wa_pend <= 1'b0;
                wd_pend <= 1'b0;
                case (wr_addr)
                    REG_CR:   cr <= wr_cr;
                    REG_CR_S: cr <= cr | wr_cr;
                    REG_CR_C: cr <= cr & ~wr_cr;
                    REG_TGT_DELAY: begin
                        // Target must lie beyond the measured link delay
                        if (wr_data > info_i.delay) begin
                            tgt_delay <= wr_data;
                            req_upd_o <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end

            // Lost link drops compensation
            if (!link_up_i) begin
                cr.dc_ena <= 1'b0;
            end
        end
    end

    always_comb begin
        mmr_rsp_o         = '0;
        mmr_rsp_o.awready = awready_q;
        mmr_rsp_o.wready  = wready_q;
        mmr_rsp_o.bvalid  = wa_pend && wd_pend;
        mmr_rsp_o.arready = arready_q;
        mmr_rsp_o.rvalid  = rd_pend;
        mmr_rsp_o.rdata   = rd_data;
    end

    assign dc_ena_o    = cr.dc_ena;
    assign delay_req_o = tgt_delay - info_i.delay;

endmodule

`default_nettype wire

// File: hw/evr_top.sv
`timescale 1ns/1ps
`default_nettype none

module evr_top #(
    parameter int DELAY_DEPTH   = 64,
    parameter int STEP_INTERVAL = 4
) (
    input  logic              rx_clk,
    input  logic              app_rst,

    input  logic              aligned_i,
    input  logic [15:0]       rx_data_i,
    input  logic [1:0]        rx_charisk_i,

    input  evr_pkg::mmr_req_t mmr_req_i,
    output evr_pkg::mmr_rsp_t mmr_rsp_o,

    output logic [7:0]        ev_o,
    output logic              beacon_o
);
    import evr_pkg::*;

    logic       link_up;
    logic [7:0] lane_data;
    logic       lane_k;

    link_info_t link_info;

    logic       dc_ena;
    mmr_data_t  delay_req;
    logic       req_upd;
    mmr_data_t  cur_delay;
    dc_status_e dc_status;

    // Low lane carries events and beacons
    event_lane event_lane_i (
        .rx_clk      (rx_clk),
        .app_rst     (app_rst),
        .aligned_i   (aligned_i),
        .lane_data_i (rx_data_i[7:0]),
        .lane_k_i    (rx_charisk_i[0]),
        .link_up_o   (link_up),
        .beacon_o    (beacon_o),
        .ev_data_o   (lane_data),
        .ev_k_o      (lane_k)
    );

    // High lane carries shared-data frames
    link_parser link_parser_i (
        .rx_clk    (rx_clk),
        .app_rst   (app_rst),
        .link_up_i (link_up),
        .sh_data_i (rx_data_i[15:8]),
        .sh_k_i    (rx_charisk_i[1]),
        .info_o    (link_info)
    );

    delay_comp #(
        .DELAY_DEPTH   (DELAY_DEPTH),
        .STEP_INTERVAL (STEP_INTERVAL)
    ) delay_comp_i (
        .rx_clk      (rx_clk),
        .app_rst     (app_rst),
        .ena_i       (dc_ena),
        .req_upd_i   (req_upd),
        .delay_req_i (delay_req),
        .lane_data_i (lane_data),
        .lane_k_i    (lane_k),
        .ev_o        (ev_o),
        .cur_delay_o (cur_delay),
        .status_o    (dc_status)
    );

    evr_regs evr_regs_i (
        .rx_clk      (rx_clk),
        .app_rst     (app_rst),
        .mmr_req_i   (mmr_req_i),
        .mmr_rsp_o   (mmr_rsp_o),
        .link_up_i   (link_up),
        .info_i      (link_info),
        .dc_status_i (dc_status),
        .cur_delay_i (cur_delay),
        .dc_ena_o    (dc_ena),
        .delay_req_o (delay_req),
        .req_upd_o   (req_upd)
    );

endmodule

`default_nettype wire

// File: hw/link_parser/link_parser.sv
`timescale 1ns/1ps
`default_nettype none

module link_parser (
    input  logic                rx_clk,
    input  logic                app_rst,
    input  logic                link_up_i,
    input  logic [7:0]          sh_data_i,
    input  logic                sh_k_i,
    output evr_pkg::link_info_t info_o
);
    import evr_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TYPE,
        ST_PAYLOAD
    } parse_st_e;

    parse_st_e   state;
    logic [1:0]  byte_cnt;
    logic        is_topo;
    logic [23:0] shift_q;
    logic [31:0] word;

    // Last payload byte completes the word, LSB first on the wire
    assign word = {sh_data_i, shift_q};

    always_ff @(posedge rx_clk) begin
        if (app_rst || !link_up_i) begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            info_o   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sh_k_i && sh_data_i == FRAME_K) begin
                        state <= ST_TYPE;
                    end
                end
                ST_TYPE: begin
                    if (!sh_k_i && (sh_data_i == MSG_TOPO || sh_data_i == MSG_DELAY)) begin
                        byte_cnt <= '0;
                        state    <= ST_PAYLOAD;
                    end else begin
                        info_o.status[2] <= 1'b1;
                        state            <= ST_IDLE;
                    end
                end
                ST_PAYLOAD: begin
                    if (sh_k_i) begin
                        // K-character breaks the frame
                        info_o.status[2] <= 1'b1;
                        state            <= ST_IDLE;
                    end else if (byte_cnt == 2'd3) begin
                        if (is_topo) begin
                            info_o.topo_id   <= word;
                            info_o.status[1] <= 1'b1;
                        end else begin
                            info_o.delay     <= word;
                            info_o.status[0] <= 1'b1;
                        end
                        state <= ST_IDLE;
                    end else begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Type and payload bytes
    always_ff @(posedge rx_clk) begin
        if (state == ST_TYPE) begin
            is_topo <= (sh_data_i == MSG_TOPO);
        end
        if (state == ST_PAYLOAD) begin
            shift_q <= {sh_data_i, shift_q[23:8]};
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the event receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module evr_tb \
    --Mdir obj_dir -f vlog.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vevr_tb > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"

// File: sim/evr_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module evr_assertions #(
    parameter int DELAY_DEPTH = 64
) (
    input  logic               rx_clk,
    input  logic               app_rst,
    input  evr_pkg::mmr_req_t  req_i,
    input  evr_pkg::mmr_rsp_t  rsp_i,
    input  logic               wa_pend_i,
    input  logic               wd_pend_i,
    input  logic               beacon_i,
    input  evr_pkg::mmr_data_t cur_delay_i
);
    import evr_pkg::*;

    // Read response held until taken
    rvalid_hold: assert property (@(posedge rx_clk) disable iff (app_rst)
        rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid && $stable(rsp_i.rdata))
        else $error("rvalid or rdata changed before rready");

    // Both write halves retire together on the response handshake
    bvalid_pend: assert property (@(posedge rx_clk) disable iff (app_rst)
        rsp_i.bvalid && req_i.bready |=> !wa_pend_i && !wd_pend_i)
        else $error("write pending flags not cleared after the response");

    beacon_single: assert property (@(posedge rx_clk) disable iff (app_rst)
        beacon_i |=> !beacon_i)
        else $error("beacon_o high for two cycles");

    // Single steps only, inside the ring
    delay_range: assert property (@(posedge rx_clk) disable iff (app_rst)
        cur_delay_i != $past(cur_delay_i) |->
            cur_delay_i <= mmr_data_t'(DELAY_DEPTH - 1)
            && (cur_delay_i == $past(cur_delay_i) + 1
                || cur_delay_i == $past(cur_delay_i) - 1))
        else $error("current delay jumped or left the ring depth");

endmodule

bind evr_top evr_assertions #(
    .DELAY_DEPTH (DELAY_DEPTH)
) asrt0 (
    .rx_clk      (rx_clk),
    .app_rst     (app_rst),
    .req_i       (mmr_req_i),
    .rsp_i       (mmr_rsp_o),
    .wa_pend_i   (evr_regs_i.wa_pend),
    .wd_pend_i   (evr_regs_i.wd_pend),
    .beacon_i    (beacon_o),
    .cur_delay_i (cur_delay)
);

`default_nettype wire

// File: sim/evr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module evr_tb;
    import evr_pkg::*;

    localparam int DELAY_DEPTH   = 64;
    localparam int STEP_INTERVAL = 4;
    localparam int WAIT_LIMIT    = 50;
    localparam int POLL_LIMIT    = 100;
    localparam int COMP_STEPS    = 10;

    logic        rx_clk;
    logic        app_rst;
    logic        aligned;
    logic [15:0] rx_data;
    logic [1:0]  rx_charisk;
    mmr_req_t    req;
    mmr_rsp_t    rsp;
    logic [7:0]  ev;
    logic        beacon;

    int          checks;
    int          errors;
    int          test_err0;
    string       cur_test;
    mmr_data_t   link_delay;

    evr_top #(
        .DELAY_DEPTH   (DELAY_DEPTH),
        .STEP_INTERVAL (STEP_INTERVAL)
    ) dut0 (
        .rx_clk       (rx_clk),
        .app_rst      (app_rst),
        .aligned_i    (aligned),
        .rx_data_i    (rx_data),
        .rx_charisk_i (rx_charisk),
        .mmr_req_i    (req),
        .mmr_rsp_o    (rsp),
        .ev_o         (ev),
        .beacon_o     (beacon)
    );

    initial begin
        rx_clk = 1'b0;
        forever #4 rx_clk = ~rx_clk;
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
                     cur_test, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timed out in %s while waiting for %s", cur_test, what);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        $display("Test %s finished with %0d errors", cur_test, errors - test_err0);
    endtask

    task automatic drive_word(input logic [15:0] data, input logic [1:0] k);
        rx_data    = data;
        rx_charisk = k;
    endtask

    // One word for one cycle, then back to idle
    task automatic send_word(input logic [15:0] data, input logic [1:0] k);
        drive_word(data, k);
        @(negedge rx_clk);
        drive_word(16'h0000, 2'b00);
    endtask

    // Shared lane frame, payload LSB first
    task automatic send_frame(input logic [7:0] msg_type, input logic [31:0] payload);
        send_word({FRAME_K, 8'h00}, 2'b10);
        send_word({msg_type, 8'h00}, 2'b00);
        for (int i = 0; i < 4; i++) begin
            send_word({payload[8*i +: 8], 8'h00}, 2'b00);
        end
    endtask

    task automatic reg_write(input mmr_addr_t addr, input mmr_data_t data);
        int   cnt;
        logic aw_done;
        logic w_done;
        cnt         = 0;
        aw_done     = 1'b0;
        w_done      = 1'b0;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.bready  = 1'b1;
        while (!(aw_done && w_done) && cnt < WAIT_LIMIT) begin
            @(negedge rx_clk);
            cnt++;
            if (rsp.awready) begin
                aw_done     = 1'b1;
                req.awvalid = 1'b0;
            end
            if (rsp.wready) begin
                w_done     = 1'b1;
                req.wvalid = 1'b0;
            end
        end
        if (!(aw_done && w_done)) begin
            report_timeout("awready and wready");
        end
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        cnt = 0;
        while (!rsp.bvalid && cnt < WAIT_LIMIT) begin
            @(negedge rx_clk);
            cnt++;
        end
        if (!rsp.bvalid) begin
            report_timeout("bvalid");
        end else begin
            check("bresp", 32'h0, 32'(rsp.bresp));
        end
        // Response completes on the next rising edge
        @(negedge rx_clk);
        req.bready = 1'b0;
    endtask

    task automatic reg_read(input mmr_addr_t addr, output mmr_data_t data);
        int cnt;
        cnt         = 0;
        data        = '0;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.rready  = 1'b0;
        while (!rsp.arready && cnt < WAIT_LIMIT) begin
            @(negedge rx_clk);
            cnt++;
        end
        if (!rsp.arready) begin
            report_timeout("arready");
        end
        req.arvalid = 1'b0;
        cnt = 0;
        while (!rsp.rvalid && cnt < WAIT_LIMIT) begin
            @(negedge rx_clk);
            cnt++;
        end
        if (!rsp.rvalid) begin
            report_timeout("rvalid");
        end else begin
            check("rresp", 32'h0, 32'(rsp.rresp));
        end
        data       = rsp.rdata;
        req.rready = 1'b1;
        @(negedge rx_clk);
        req.rready = 1'b0;
    endtask

    task automatic read_check(input string what, input mmr_addr_t addr, input mmr_data_t exp);
        mmr_data_t rd;
        reg_read(addr, rd);
        check(what, exp, rd);
    endtask

    // SR bits 5:4 hold the compensator state
    task automatic wait_dc_status(input logic [1:0] want);
        mmr_data_t sr;
        int        polls;
        polls = 0;
        reg_read(REG_SR, sr);
        while (sr[5:4] != want && polls < POLL_LIMIT) begin
            reg_read(REG_SR, sr);
            polls++;
        end
        if (sr[5:4] != want) begin
            report_timeout("delay compensator state");
        end
    endtask

    task automatic test_reset_link();
        begin_test("reset_link");
        read_check("sr", REG_SR, 32'h0);
        read_check("cr", REG_CR, 32'h0);
        aligned = 1'b1;
        repeat (3) @(negedge rx_clk);
        read_check("sr link_up", REG_SR, 32'h1);
        end_test();
    endtask

    task automatic test_link_parse();
        mmr_data_t topo;
        mmr_data_t dly;
        begin_test("link_parse");
        topo = $urandom;
        dly  = $urandom;
        send_frame(MSG_TOPO, topo);
        send_frame(MSG_DELAY, dly);
        read_check("topo_id", REG_TOPO_ID, topo);
        read_check("link_delay", REG_LINK_DELAY, dly);
        read_check("sr status 011", REG_SR, 32'h7);
        send_frame(8'h33, $urandom);
        read_check("sr frame error", REG_SR, 32'hF);
        end_test();
    endtask

    task automatic test_control();
        begin_test("control");
        reg_write(REG_CR_S, 32'h1);
        read_check("cr set", REG_CR, 32'h1);
        reg_write(REG_CR_C, 32'h1);
        read_check("cr clear", REG_CR, 32'h0);
        link_delay = 32'd16 + ($urandom % 32'd200);
        send_frame(MSG_DELAY, link_delay);
        read_check("link_delay", REG_LINK_DELAY, link_delay);
        read_check("tgt initial", REG_TGT_DELAY, 32'h0);
        reg_write(REG_TGT_DELAY, link_delay);
        read_check("tgt equal rejected", REG_TGT_DELAY, 32'h0);
        reg_write(REG_TGT_DELAY, link_delay - 32'd1);
        read_check("tgt below rejected", REG_TGT_DELAY, 32'h0);
        reg_write(REG_TGT_DELAY, link_delay + 32'd5);
        read_check("tgt stored", REG_TGT_DELAY, link_delay + 32'd5);
        end_test();
    endtask

    task automatic test_delay_comp();
        logic [7:0] ev_byte;
        logic [31:0] exp;
        begin_test("delay_comp");
        reg_write(REG_TGT_DELAY, link_delay + 32'(COMP_STEPS));
        reg_write(REG_CR_S, 32'h1);
        wait_dc_status(DC_LOCKED);
        read_check("comp_delay", REG_COMP_DELAY, 32'(COMP_STEPS));
        ev_byte = 8'($urandom);
        while (ev_byte == 8'h00 || ev_byte == BEACON_CODE || ev_byte == 8'hBC) begin
            ev_byte = 8'($urandom);
        end
        drive_word({8'h00, ev_byte}, 2'b00);
        for (int k = 1; k <= 2 * COMP_STEPS + 4; k++) begin
            @(negedge rx_clk);
            if (k == 1) begin
                drive_word(16'h0000, 2'b00);
            end
            exp = (k == COMP_STEPS + 2) ? {24'h0, ev_byte} : 32'h0;
            check($sformatf("ev_o cycle %0d", k), exp, {24'h0, ev});
        end
        // Difference of DELAY_DEPTH + 5 is out of range
        reg_write(REG_TGT_DELAY, link_delay + 32'(DELAY_DEPTH + 5));
        wait_dc_status(DC_RANGE);
        reg_write(REG_CR_C, 32'h1);
        end_test();
    endtask

    task automatic test_beacons();
        int pulses;
        int beacon_seen;
        int comma_seen;
        begin_test("beacons");
        pulses      = 0;
        beacon_seen = 0;
        comma_seen  = 0;
        drive_word({8'h00, BEACON_CODE}, 2'b00);
        for (int k = 0; k < DELAY_DEPTH + 16; k++) begin
            @(negedge rx_clk);
            if (k == 0) begin
                drive_word({8'h00, 8'hBC}, 2'b01);
            end else if (k == 1) begin
                drive_word(16'h0000, 2'b00);
            end
            pulses      += int'(beacon);
            beacon_seen += int'(ev == BEACON_CODE);
            comma_seen  += int'(ev == 8'hBC);
        end
        check("beacon pulses", 32'd1, 32'(pulses));
        check("beacon on ev_o", 32'd0, 32'(beacon_seen));
        check("comma on ev_o", 32'd0, 32'(comma_seen));
        end_test();
    endtask

    task automatic test_link_loss();
        begin_test("link_loss");
        reg_write(REG_CR_S, 32'h1);
        read_check("cr enabled", REG_CR, 32'h1);
        aligned = 1'b0;
        repeat (4) @(negedge rx_clk);
        read_check("cr after loss", REG_CR, 32'h0);
        read_check("sr after loss", REG_SR, 32'h0);
        aligned = 1'b1;
        repeat (4) @(negedge rx_clk);
        read_check("topo_id cleared", REG_TOPO_ID, 32'h0);
        read_check("sr relinked", REG_SR, 32'h1);
        end_test();
    endtask

    initial begin
        void'($urandom(32'h6310));
        app_rst    = 1'b1;
        aligned    = 1'b0;
        rx_data    = '0;
        rx_charisk = '0;
        req        = '0;
        checks     = 0;
        errors     = 0;
        test_err0  = 0;
        link_delay = '0;
        cur_test   = "none";
        repeat (10) @(negedge rx_clk);
        app_rst = 1'b0;
        @(negedge rx_clk);

        test_reset_link();
        test_link_parse();
        test_control();
        test_delay_comp();
        test_beacons();
        test_link_loss();

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/evr_pkg.sv
hw/event_lane.sv
hw/link_parser/link_parser.sv
hw/delay_comp/delay_comp.sv
hw/evr_regs/evr_regs.sv
hw/evr_top.sv
sim/evr_assertions.sv
sim/evr_tb.sv
